//--- build.f
+incdir+include
hdl/axil_pkg.sv
hdl/axil_chan_slice.sv
hdl/gpio_edge_capture.sv
hdl/axil_gpio_regs.sv
hdl/gpio_subsys_top.sv
test/gpio_subsys_tb.sv

//--- include/axil_tb_tasks.svh
`ifndef AXIL_TB_TASKS_SVH
`define AXIL_TB_TASKS_SVH

// ----------------------------------------
// Checking
// ----------------------------------------

// Compare one value, count and report a mismatch
task automatic compare_value(
  input string                       name,
  input logic [axil_pkg::DATA_W-1:0] expected,
  input logic [axil_pkg::DATA_W-1:0] actual
);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("mismatch at %0t ns: %s expected 0x%08h got 0x%08h",
             $time, name, expected, actual);
  end
endtask

// Returns once the given number of rising edges has passed
task automatic watch_cycles(input int limit);
  int count;
  count = 0;
  while (count < limit) begin
    @(posedge bus);
    count++;
  end
endtask

// ----------------------------------------
// AXI4-Lite manager
// ----------------------------------------

// All tasks start and end just after a rising edge
// Outputs read there are the values the DUT sampled at that edge

// Write with AW and W issued together, B held off for hold cycles
task automatic write_reg(
  input  logic [axil_pkg::ADDR_W-1:0] addr,
  input  logic [axil_pkg::DATA_W-1:0] data,
  input  logic [axil_pkg::STRB_W-1:0] strb,
  input  int                          hold,
  output logic [1:0]                  resp
);
  logic aw_done;
  logic w_done;
  aw_done = 1'b0;
  w_done  = 1'b0;
  s_aw.addr  <= addr;
  s_aw_valid <= 1'b1;
  s_w.data   <= data;
  s_w.strb   <= strb;
  s_w_valid  <= 1'b1;
  // Each channel drops valid after its own handshake
  while (!(aw_done && w_done)) begin
    @(posedge bus);
    if (!aw_done && s_aw_ready) begin
      aw_done = 1'b1;
      s_aw_valid <= 1'b0;
    end
    if (!w_done && s_w_ready) begin
      w_done = 1'b1;
      s_w_valid <= 1'b0;
    end
  end
  while (!s_b_valid) begin
    @(posedge bus);
  end
  resp = s_b.resp;
  // Ready held low, response must not move
  repeat (hold) begin
    @(posedge bus);
    compare_value("s_b_valid", 1'b1, s_b_valid);
    compare_value("s_b.resp", resp, s_b.resp);
  end
  s_b_ready <= 1'b1;
  @(posedge bus);
  compare_value("s_b_valid", 1'b1, s_b_valid);
  s_b_ready <= 1'b0;
endtask

// Read with R held off for hold cycles
task automatic read_reg(
  input  logic [axil_pkg::ADDR_W-1:0] addr,
  input  int                          hold,
  output logic [axil_pkg::DATA_W-1:0] data,
  output logic [1:0]                  resp
);
  s_ar.addr  <= addr;
  s_ar_valid <= 1'b1;
  do begin
    @(posedge bus);
  end while (!s_ar_ready);
  s_ar_valid <= 1'b0;
  while (!s_r_valid) begin
    @(posedge bus);
  end
  data = s_r.data;
  resp = s_r.resp;
  repeat (hold) begin
    @(posedge bus);
    compare_value("s_r_valid", 1'b1, s_r_valid);
    compare_value("s_r.data", data, s_r.data);
    compare_value("s_r.resp", resp, s_r.resp);
  end
  s_r_ready <= 1'b1;
  @(posedge bus);
  compare_value("s_r_valid", 1'b1, s_r_valid);
  s_r_ready <= 1'b0;
endtask

`endif

//--- test/gpio_subsys_tb.sv
module gpio_subsys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PINS    = 20;
  localparam int SYNC_STAGES = 2;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_STEPS   = 29;
  localparam int CYCLE_LIMIT = 64 * NUM_STEPS + RESET_CYCLES;

  // Byte addresses of the register map
  localparam logic [4:0] A_OUT  = {axil_pkg::REG_OUT, 2'b00};
  localparam logic [4:0] A_TRI  = {axil_pkg::REG_TRI, 2'b00};
  localparam logic [4:0] A_IN   = {axil_pkg::REG_IN, 2'b00};
  localparam logic [4:0] A_EN   = {axil_pkg::REG_IRQ_EN, 2'b00};
  localparam logic [4:0] A_STAT = {axil_pkg::REG_IRQ_STAT, 2'b00};
  // Unmapped word offsets 5 and 7
  localparam logic [4:0] A_BAD5 = 5'h14;
  localparam logic [4:0] A_BAD7 = 5'h1c;
  // Delay code meaning a random back-pressure gap
  localparam logic [3:0] RND = 4'hf;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_PINS} op_e;

  typedef struct packed {
    op_e         op;
    logic [4:0]  addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [3:0]  delay;
  } step_t;

  logic                bus;
  logic                rst_n;
  axil_pkg::aw_chan_t  s_aw;
  logic                s_aw_valid;
  logic                s_aw_ready;
  axil_pkg::w_chan_t   s_w;
  logic                s_w_valid;
  logic                s_w_ready;
  axil_pkg::b_chan_t   s_b;
  logic                s_b_valid;
  logic                s_b_ready;
  axil_pkg::ar_chan_t  s_ar;
  logic                s_ar_valid;
  logic                s_ar_ready;
  axil_pkg::r_chan_t   s_r;
  logic                s_r_valid;
  logic                s_r_ready;
  logic [NUM_PINS-1:0] gpio_i;
  logic [NUM_PINS-1:0] gpio_o;
  logic [NUM_PINS-1:0] gpio_t;
  logic                irq;

  int checks = 0;
  int errors = 0;

  // Shadow registers of the reference model
  logic [NUM_PINS-1:0] sh_out  = '0;
  logic [NUM_PINS-1:0] sh_tri  = '0;
  logic [NUM_PINS-1:0] sh_en   = '0;
  logic [NUM_PINS-1:0] sh_stat = '0;
  logic [NUM_PINS-1:0] sh_pins = '0;

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------

  step_t steps [NUM_STEPS] = '{
    '{OP_WR,   A_OUT,  32'hdead_beef, 4'hf, 4'd0},
    '{OP_RD,   A_OUT,  32'h0,         4'h0, 4'd0},
    '{OP_WR,   A_OUT,  32'h1234_5678, 4'h2, RND},
    '{OP_RD,   A_OUT,  32'h0,         4'h0, RND},
    '{OP_WR,   A_OUT,  32'hffff_ffff, 4'h4, RND},
    '{OP_RD,   A_OUT,  32'h0,         4'h0, 4'd0},
    '{OP_WR,   A_OUT,  32'h00a0_0c00, 4'h9, RND},
    '{OP_RD,   A_OUT,  32'h0,         4'h0, RND},
    '{OP_WR,   A_TRI,  32'h000f_0f0f, 4'hf, RND},
    '{OP_RD,   A_TRI,  32'h0,         4'h0, RND},
    '{OP_PINS, A_IN,   32'h0000_00a5, 4'h0, 4'd0},
    '{OP_WR,   A_IN,   32'h0001_2345, 4'hf, RND},
    '{OP_RD,   A_IN,   32'h0,         4'h0, RND},
    '{OP_PINS, A_IN,   32'h000a_55a5, 4'h0, 4'd0},
    '{OP_RD,   A_IN,   32'h0,         4'h0, 4'd0},
    '{OP_RD,   A_STAT, 32'h0,         4'h0, RND},
    '{OP_WR,   A_EN,   32'h0000_0001, 4'hf, RND},
    '{OP_RD,   A_EN,   32'h0,         4'h0, RND},
    '{OP_WR,   A_STAT, 32'h0000_0001, 4'h1, RND},
    '{OP_RD,   A_STAT, 32'h0,         4'h0, RND},
    '{OP_PINS, A_IN,   32'h0000_0000, 4'h0, 4'd0},
    '{OP_PINS, A_IN,   32'h0000_0001, 4'h0, 4'd0},
    '{OP_WR,   A_STAT, 32'hffff_ffff, 4'hf, RND},
    '{OP_WR,   A_BAD5, 32'hffff_ffff, 4'hf, RND},
    '{OP_RD,   A_BAD5, 32'h0,         4'h0, RND},
    '{OP_WR,   A_BAD7, 32'h5555_5555, 4'hf, 4'd0},
    '{OP_RD,   A_BAD7, 32'h0,         4'h0, RND},
    '{OP_RD,   A_TRI,  32'h0,         4'h0, RND},
    '{OP_RD,   A_EN,   32'h0,         4'h0, RND}
  };

  gpio_subsys_top #(
    .NUM_PINS   (NUM_PINS),
    .SYNC_STAGES(SYNC_STAGES)
  ) dut_i (
    .bus, .rst_n,
    .s_aw, .s_aw_valid, .s_aw_ready,
    .s_w,  .s_w_valid,  .s_w_ready,
    .s_b,  .s_b_valid,  .s_b_ready,
    .s_ar, .s_ar_valid, .s_ar_ready,
    .s_r,  .s_r_valid,  .s_r_ready,
    .gpio_i, .gpio_o, .gpio_t, .irq
  );

  `include "axil_tb_tasks.svh"

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Replace the strobed bytes, then keep only the pin bits
  function automatic logic [NUM_PINS-1:0] merge_bytes(
    input logic [NUM_PINS-1:0] old_val,
    input logic [31:0]         data,
    input logic [3:0]          strb
  );
    logic [31:0] merged;
    merged = 32'(old_val);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) merged[i*8 +: 8] = data[i*8 +: 8];
    end
    return merged[NUM_PINS-1:0];
  endfunction

  // Only the five mapped word offsets answer OKAY
  function automatic logic [1:0] expected_resp(input logic [4:0] addr);
    case (addr[4:2])
      axil_pkg::REG_OUT,
      axil_pkg::REG_TRI,
      axil_pkg::REG_IN,
      axil_pkg::REG_IRQ_EN,
      axil_pkg::REG_IRQ_STAT: return axil_pkg::RESP_OKAY;
      default:                return axil_pkg::RESP_SLVERR;
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [4:0] addr);
    case (addr[4:2])
      axil_pkg::REG_OUT:      return 32'(sh_out);
      axil_pkg::REG_TRI:      return 32'(sh_tri);
      axil_pkg::REG_IN:       return 32'(sh_pins);
      axil_pkg::REG_IRQ_EN:   return 32'(sh_en);
      axil_pkg::REG_IRQ_STAT: return 32'(sh_stat);
      default:                return 32'h0;
    endcase
  endfunction

  // IN and unmapped offsets change nothing
  function automatic void apply_write_rules(
    input logic [4:0]  addr,
    input logic [31:0] data,
    input logic [3:0]  strb
  );
    case (addr[4:2])
      axil_pkg::REG_OUT:      sh_out = merge_bytes(sh_out, data, strb);
      axil_pkg::REG_TRI:      sh_tri = merge_bytes(sh_tri, data, strb);
      axil_pkg::REG_IRQ_EN:   sh_en = merge_bytes(sh_en, data, strb);
      axil_pkg::REG_IRQ_STAT: sh_stat = sh_stat & ~merge_bytes('0, data, strb);
      default: ;
    endcase
  endfunction

  // Rising pins set sticky status regardless of enables
  function automatic void apply_pin_rules(input logic [NUM_PINS-1:0] pins);
    sh_stat = sh_stat | (pins & ~sh_pins);
    sh_pins = pins;
  endfunction

  // ----------------------------------------
  // Clock, reset and run
  // ----------------------------------------

  always #5 bus = ~bus;

  initial begin
    watch_cycles(CYCLE_LIMIT);
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int          seed_draw;
    int          hold;
    logic [1:0]  resp;
    logic [31:0] rdata;
    bus        = 1'b0;
    rst_n      = 1'b0;
    s_aw       = '0;
    s_aw_valid = 1'b0;
    s_w        = '0;
    s_w_valid  = 1'b0;
    s_b_ready  = 1'b0;
    s_ar       = '0;
    s_ar_valid = 1'b0;
    s_r_ready  = 1'b0;
    gpio_i     = '0;
    seed_draw  = $urandom(56);
    repeat (RESET_CYCLES) @(posedge bus);
    rst_n <= 1'b1;
    @(posedge bus);
    // Idle bus after reset
    compare_value("s_aw_ready", 1'b1, s_aw_ready);
    compare_value("s_w_ready", 1'b1, s_w_ready);
    compare_value("s_ar_ready", 1'b1, s_ar_ready);
    compare_value("s_b_valid", 1'b0, s_b_valid);
    compare_value("s_r_valid", 1'b0, s_r_valid);
    for (int i = 0; i < NUM_STEPS; i++) begin
      hold = (steps[i].delay == RND) ? int'($urandom % 8) : int'(steps[i].delay);
      case (steps[i].op)
        OP_WR: begin
          write_reg(steps[i].addr, steps[i].data, steps[i].strb, hold, resp);
          compare_value("write resp", expected_resp(steps[i].addr), resp);
          apply_write_rules(steps[i].addr, steps[i].data, steps[i].strb);
        end
        OP_RD: begin
          read_reg(steps[i].addr, hold, rdata, resp);
          compare_value("read resp", expected_resp(steps[i].addr), resp);
          compare_value("read data", expected_read(steps[i].addr), rdata);
        end
        default: begin
          gpio_i <= steps[i].data[NUM_PINS-1:0];
          apply_pin_rules(steps[i].data[NUM_PINS-1:0]);
          // Synchronizer, status flop and irq flop
          repeat (SYNC_STAGES + 3) @(posedge bus);
        end
      endcase
      // irq lags a status or enable change by one more edge
      repeat (2) @(posedge bus);
      compare_value("gpio_o", sh_out, gpio_o);
      compare_value("gpio_t", sh_tri, gpio_t);
      compare_value("irq", |(sh_stat & sh_en), irq);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- hdl/gpio_subsys_top.sv
module gpio_subsys_top #(
  parameter int NUM_PINS    = 20,
  parameter int SYNC_STAGES = 2
) (
  input  logic                bus,
  input  logic                rst_n,
  input  axil_pkg::aw_chan_t  s_aw,
  input  logic                s_aw_valid,
  output logic                s_aw_ready,
  input  axil_pkg::w_chan_t   s_w,
  input  logic                s_w_valid,
  output logic                s_w_ready,
  output axil_pkg::b_chan_t   s_b,
  output logic                s_b_valid,
  input  logic                s_b_ready,
  input  axil_pkg::ar_chan_t  s_ar,
  input  logic                s_ar_valid,
  output logic                s_ar_ready,
  output axil_pkg::r_chan_t   s_r,
  output logic                s_r_valid,
  input  logic                s_r_ready,
  input  logic [NUM_PINS-1:0] gpio_i,
  output logic [NUM_PINS-1:0] gpio_o,
  output logic [NUM_PINS-1:0] gpio_t,
  output logic                irq
);

  // Request streams after the slices
  axil_pkg::aw_chan_t  aw;
  logic                aw_valid;
  logic                aw_ready;
  axil_pkg::w_chan_t   w;
  logic                w_valid;
  logic                w_ready;
  axil_pkg::ar_chan_t  ar;
  logic                ar_valid;
  logic                ar_ready;

  // Register block to edge capture
  logic [NUM_PINS-1:0] irq_en;
  logic [NUM_PINS-1:0] stat_clr;
  logic [NUM_PINS-1:0] pins_sync;
  logic [NUM_PINS-1:0] irq_stat;

  // ----------------------------------------
  // Request slices
  // ----------------------------------------

  axil_chan_slice #(.payload_t(axil_pkg::aw_chan_t)) aw_slice_i (
    .bus, .rst_n,
    .in_data (s_aw), .in_valid (s_aw_valid), .in_ready (s_aw_ready),
    .out_data(aw),   .out_valid(aw_valid),   .out_ready(aw_ready)
  );

  axil_chan_slice #(.payload_t(axil_pkg::w_chan_t)) w_slice_i (
    .bus, .rst_n,
    .in_data (s_w), .in_valid (s_w_valid), .in_ready (s_w_ready),
    .out_data(w),   .out_valid(w_valid),   .out_ready(w_ready)
  );

  axil_chan_slice #(.payload_t(axil_pkg::ar_chan_t)) ar_slice_i (
    .bus, .rst_n,
    .in_data (s_ar), .in_valid (s_ar_valid), .in_ready (s_ar_ready),
    .out_data(ar),   .out_valid(ar_valid),   .out_ready(ar_ready)
  );

  // ----------------------------------------
  // Registers and pin logic
  // ----------------------------------------

  // B and R leave without a slice
  axil_gpio_regs #(.NUM_PINS(NUM_PINS)) regs_i (
    .bus, .rst_n,
    .aw, .aw_valid, .aw_ready,
    .w,  .w_valid,  .w_ready,
    .b   (s_b), .b_valid(s_b_valid), .b_ready(s_b_ready),
    .ar, .ar_valid, .ar_ready,
    .r   (s_r), .r_valid(s_r_valid), .r_ready(s_r_ready),
    .gpio_o, .gpio_t, .irq_en, .stat_clr, .pins_sync, .irq_stat
  );

  gpio_edge_capture #(.NUM_PINS(NUM_PINS), .SYNC_STAGES(SYNC_STAGES)) edge_i (
    .bus, .rst_n,
    .gpio_i, .irq_en, .stat_clr, .pins_sync, .irq_stat, .irq
  );

endmodule

//--- hdl/axil_gpio_regs.sv
module axil_gpio_regs #(
  parameter int NUM_PINS = 32
) (
  input  logic                bus,
  input  logic                rst_n,
  input  axil_pkg::aw_chan_t  aw,
  input  logic                aw_valid,
  output logic                aw_ready,
  input  axil_pkg::w_chan_t   w,
  input  logic                w_valid,
  output logic                w_ready,
  output axil_pkg::b_chan_t   b,
  output logic                b_valid,
  input  logic                b_ready,
  input  axil_pkg::ar_chan_t  ar,
  input  logic                ar_valid,
  output logic                ar_ready,
  output axil_pkg::r_chan_t   r,
  output logic                r_valid,
  input  logic                r_ready,
  output logic [NUM_PINS-1:0] gpio_o,
  output logic [NUM_PINS-1:0] gpio_t,
  output logic [NUM_PINS-1:0] irq_en,
  output logic [NUM_PINS-1:0] stat_clr,
  input  logic [NUM_PINS-1:0] pins_sync,
  input  logic [NUM_PINS-1:0] irq_stat
);

  // Expand byte strobes to a bit mask
  function automatic logic [axil_pkg::DATA_W-1:0] byte_mask(
    input logic [axil_pkg::STRB_W-1:0] strb
  );
    logic [axil_pkg::DATA_W-1:0] m;
    for (int i = 0; i < axil_pkg::STRB_W; i++) begin
      m[i*8 +: 8] = {8{strb[i]}};
    end
    return m;
  endfunction

  // Single ready flop drives both AW and W, they are taken as a pair
  logic                        wr_ready;
  logic                        wr_en;
  axil_pkg::word_addr_t        wr_word;
  logic                        wr_hit;
  logic [axil_pkg::DATA_W-1:0] wr_mask_full;
  logic [NUM_PINS-1:0]         wr_mask;
  logic [NUM_PINS-1:0]         wr_data;

  logic                        rd_en;
  axil_pkg::word_addr_t        rd_word;
  logic [axil_pkg::DATA_W-1:0] rd_data;
  logic [1:0]                  rd_resp;

  // ----------------------------------------
  // Write channel
  // ----------------------------------------

  assign aw_ready = wr_ready;
  assign w_ready  = wr_ready;
  assign wr_en    = aw_ready && aw_valid && w_ready && w_valid;

  assign wr_word      = aw.addr[axil_pkg::ADDR_W-1:axil_pkg::ADDR_LSB];
  assign wr_hit       = (wr_word <= axil_pkg::REG_IRQ_STAT);
  assign wr_mask_full = byte_mask(w.strb);
  // High bits beyond NUM_PINS are dropped here
  assign wr_mask      = wr_mask_full[NUM_PINS-1:0];
  assign wr_data      = w.data[NUM_PINS-1:0];

  // One-cycle ready pulse, held off while a response waits
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready <= 1'b0;
    end else begin
      wr_ready <= !wr_ready && aw_valid && w_valid && !b_valid;
    end
  end

  // Strobed register updates
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      gpio_o <= '0;
      gpio_t <= '0;
      irq_en <= '0;
    end else if (wr_en) begin
      case (wr_word)
        axil_pkg::REG_OUT:    gpio_o <= (gpio_o & ~wr_mask) | (wr_data & wr_mask);
        axil_pkg::REG_TRI:    gpio_t <= (gpio_t & ~wr_mask) | (wr_data & wr_mask);
        axil_pkg::REG_IRQ_EN: irq_en <= (irq_en & ~wr_mask) | (wr_data & wr_mask);
        // IN is read-only, IRQ_STAT goes out as a clear mask
        default: ;
      endcase
    end
  end

  // Write-one-to-clear pulse toward the edge capture
  assign stat_clr = (wr_en && wr_word == axil_pkg::REG_IRQ_STAT) ? (wr_data & wr_mask) : '0;

  // B response
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      b_valid <= 1'b0;
    end else if (wr_en) begin
      b_valid <= 1'b1;
    end else if (b_ready) begin
      b_valid <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (wr_en) begin
      b.resp <= wr_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
    end
  end

  // ----------------------------------------
  // Read channel
  // ----------------------------------------

  assign rd_en   = ar_ready && ar_valid;
  assign rd_word = ar.addr[axil_pkg::ADDR_W-1:axil_pkg::ADDR_LSB];

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready <= 1'b0;
    end else begin
      ar_ready <= !ar_ready && ar_valid && !r_valid;
    end
  end

  // Read mux, zero-extended to the bus width
  always_comb begin
    rd_data = '0;
    rd_resp = axil_pkg::RESP_OKAY;
    case (rd_word)
      axil_pkg::REG_OUT:      rd_data[NUM_PINS-1:0] = gpio_o;
      axil_pkg::REG_TRI:      rd_data[NUM_PINS-1:0] = gpio_t;
      axil_pkg::REG_IN:       rd_data[NUM_PINS-1:0] = pins_sync;
      axil_pkg::REG_IRQ_EN:   rd_data[NUM_PINS-1:0] = irq_en;
      axil_pkg::REG_IRQ_STAT: rd_data[NUM_PINS-1:0] = irq_stat;
      // Offsets 5 to 7 are unmapped
      default:                rd_resp = axil_pkg::RESP_SLVERR;
    endcase
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
    end else if (rd_en) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (rd_en) begin
      r.data <= rd_data;
      r.resp <= rd_resp;
    end
  end

endmodule

//--- hdl/gpio_edge_capture.sv
module gpio_edge_capture #(
  parameter int NUM_PINS    = 32,
  parameter int SYNC_STAGES = 2
) (
  input  logic                bus,
  input  logic                rst_n,
  input  logic [NUM_PINS-1:0] gpio_i,
  input  logic [NUM_PINS-1:0] irq_en,
  input  logic [NUM_PINS-1:0] stat_clr,
  output logic [NUM_PINS-1:0] pins_sync,
  output logic [NUM_PINS-1:0] irq_stat,
  output logic                irq
);

  // Synchronizer chain, stage 0 samples the pads
  logic [NUM_PINS-1:0] sync_q [SYNC_STAGES];

  // Previous synchronized value for edge detection
  logic [NUM_PINS-1:0] pins_prev;
  logic [NUM_PINS-1:0] rise;

  assign pins_sync = sync_q[SYNC_STAGES-1];
  assign rise      = pins_sync & ~pins_prev;

  // ----------------------------------------
  // Synchronizer and edge history
  // ----------------------------------------

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      sync_q    <= '{default: '0};
      pins_prev <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      pins_prev <= pins_sync;
    end
  end

  // ----------------------------------------
  // Sticky status and interrupt
  // ----------------------------------------

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      irq_stat <= '0;
      irq      <= 1'b0;
    end else begin
      // Set after clear, so a new edge beats a same-cycle clear
      irq_stat <= (irq_stat & ~stat_clr) | rise;
      // Registered, lags the status by one edge
      irq      <= |(irq_stat & irq_en);
    end
  end

endmodule

//--- hdl/axil_chan_slice.sv
module axil_chan_slice #(
  parameter type payload_t = axil_pkg::w_chan_t
) (
  input  logic     bus,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // Skid entry, filled only while the main entry is stalled
  payload_t skid_data;
  logic     skid_valid;

  // Main entry may take a new beat this cycle
  logic     main_load;
  logic     in_fire;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // in_ready depends on the skid flag only, never on out_ready
  assign in_ready  = !skid_valid;
  assign in_fire   = in_valid && in_ready;
  assign main_load = out_ready || !out_valid;

  // ----------------------------------------
  // Valid flags
  // ----------------------------------------

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      // Skid drains first, input is held off while it is full
      if (skid_valid) begin
        out_valid  <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        out_valid <= in_valid;
      end
    end else if (in_fire) begin
      // Main stalled, park the incoming beat
      skid_valid <= 1'b1;
    end
  end

  // ----------------------------------------
  // Payload
  // ----------------------------------------

  always_ff @(posedge bus) begin
    if (main_load) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (!main_load && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- hdl/axil_pkg.sv
package axil_pkg;

  // ----------------------------------------
  // Bus geometry
  // ----------------------------------------

  // Data width is fixed because the channel structs below depend on it
  localparam int DATA_W = 32;

  // Byte address covers eight 32-bit words
  localparam int ADDR_W = 5;

  // One strobe per data byte
  localparam int STRB_W = DATA_W / 8;

  // Byte offset bits dropped to form the word offset
  localparam int ADDR_LSB = 2;

  // Word offset inside the register window
  typedef logic [ADDR_W-ADDR_LSB-1:0] word_addr_t;

  // ----------------------------------------
  // Response codes
  // ----------------------------------------

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ----------------------------------------
  // Register map, word offsets
  // ----------------------------------------

  localparam word_addr_t REG_OUT      = 3'd0;
  localparam word_addr_t REG_TRI      = 3'd1;
  localparam word_addr_t REG_IN       = 3'd2;
  localparam word_addr_t REG_IRQ_EN   = 3'd3;
  localparam word_addr_t REG_IRQ_STAT = 3'd4;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------

  // Write address
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } aw_chan_t;

  // Write data with byte strobes
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  // Write response
  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  // Read address
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } ar_chan_t;

  // Read data with response
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } r_chan_t;

endpackage
